// ==== ahb_ram_pkg.sv ====
package ahb_ram_pkg;

    // HTRANS codes as seen on the bus
    localparam logic [1:0] htrans_idle   = 2'b00;
    localparam logic [1:0] htrans_busy   = 2'b01;
    localparam logic [1:0] htrans_nonseq = 2'b10;
    localparam logic [1:0] htrans_seq    = 2'b11;

    // anything above a word is treated as oversized by this slave
    localparam logic [2:0] hsize_byte = 3'b000;
    localparam logic [2:0] hsize_half = 3'b001;
    localparam logic [2:0] hsize_word = 3'b010;

    localparam logic hresp_okay  = 1'b0;
    localparam logic hresp_error = 1'b1;

    localparam int byte_lanes = 4;

    // the bus and the read path see a whole word, the write merge sees lanes
    typedef union packed {
        logic [byte_lanes*8-1:0]    word;
        logic [byte_lanes-1:0][7:0] bytes;
    } word_t;

endpackage

// ==== ahb_ram_if.sv ====
interface ahb_ram_if #(
    parameter int addr_width = 10
) ();

    logic                                read_enable;
    logic [addr_width-1:0]               read_addr;
    logic                                write_enable;
    logic [addr_width-1:0]               write_addr;
    logic [ahb_ram_pkg::byte_lanes-1:0]  write_mask;
    logic                                raw_stall;   // read hits the word still in flight
    logic                                size_error;  // accepted transfer wider than a word

    modport decode (
        output read_enable,
        output read_addr,
        output write_enable,
        output write_addr,
        output write_mask,
        output raw_stall,
        output size_error
    );

    modport array (
        input read_enable,
        input read_addr,
        input write_enable,
        input write_addr,
        input write_mask
    );

    modport resp (
        input raw_stall,
        input size_error
    );

endinterface

// ==== ahb_ram_decode.sv ====
module ahb_ram_decode #(
    parameter int addr_width = 10
) (
    input  logic                  HCLK,
    input  logic                  HRESETn,
    input  logic                  HSEL,
    input  logic [addr_width+1:0] HADDR,
    input  logic [1:0]            HTRANS,
    input  logic [2:0]            HSIZE,
    input  logic                  HWRITE,
    input  logic                  HREADY,
    input  logic                  bus_ready,
    ahb_ram_if.decode             dec
);

    logic                                request;
    logic                                oversized;
    logic                                read_request;
    logic                                write_request;
    logic [addr_width-1:0]               haddr_word;
    logic [addr_width-1:0]               held_addr;
    logic                                held_read;
    logic [ahb_ram_pkg::byte_lanes-1:0]  lane_mask;

    // BUSY and IDLE carry no transfer, a stalled bus does not accept one either
    assign request = HSEL && HREADY &&
                     (HTRANS == ahb_ram_pkg::htrans_nonseq ||
                      HTRANS == ahb_ram_pkg::htrans_seq);

    assign oversized     = HSIZE > ahb_ram_pkg::hsize_word;
    assign read_request  = request && !HWRITE && !oversized;
    assign write_request = request && HWRITE && !oversized;
    assign haddr_word    = HADDR[addr_width+1:2];

    always_comb begin
        case (HSIZE)
            ahb_ram_pkg::hsize_byte: lane_mask = 4'b0001 << HADDR[1:0];
            ahb_ram_pkg::hsize_half: lane_mask = HADDR[1] ? 4'b1100 : 4'b0011;
            ahb_ram_pkg::hsize_word: lane_mask = 4'b1111;
            default:                 lane_mask = 4'b0000;
        endcase
    end

    // while the response is held low a read is taken again from the held address
    assign dec.read_enable = read_request || (held_read && !bus_ready);
    assign dec.read_addr   = read_request ? haddr_word : held_addr;
    assign dec.write_addr  = held_addr;

    assign dec.raw_stall  = read_request && dec.write_enable && (haddr_word == held_addr);
    assign dec.size_error = request && oversized; // one cycle, the bus stalls right after

    always_ff @(posedge HCLK) begin
        if (!HRESETn) begin
            dec.write_enable <= 1'b0;
            dec.write_mask   <= '0;
            held_read        <= 1'b0;
        end else begin
            dec.write_enable <= write_request;
            dec.write_mask   <= write_request ? lane_mask : 4'b0000;
            held_read        <= read_request;
        end
    end

    always_ff @(posedge HCLK) begin
        if (request) begin
            held_addr <= haddr_word;
        end
    end

endmodule

// ==== ahb_ram_array.sv ====
module ahb_ram_array #(
    parameter int addr_width = 10
) (
    input  logic               HCLK,
    ahb_ram_if.array           mem,
    input  ahb_ram_pkg::word_t HWDATA,
    output ahb_ram_pkg::word_t rdata
);

    localparam int depth = 2 ** addr_width;

    ahb_ram_pkg::word_t ram [depth];

    // each lane is written on its own so untouched bytes keep their value
    always_ff @(posedge HCLK) begin
        if (mem.write_enable) begin
            for (int lane = 0; lane < ahb_ram_pkg::byte_lanes; lane++) begin
                if (mem.write_mask[lane]) begin
                    ram[mem.write_addr].bytes[lane] <= HWDATA.bytes[lane];
                end
            end
        end
    end

    // read sees the old word when a write to it lands on the same edge
    always_ff @(posedge HCLK) begin
        if (mem.read_enable) begin
            rdata <= ram[mem.read_addr];
        end
    end

endmodule

// ==== ahb_ram_resp.sv ====
module ahb_ram_resp (
    input  logic               HCLK,
    input  logic               HRESETn,
    ahb_ram_if.resp            rsp,
    input  ahb_ram_pkg::word_t rdata,
    output logic               HREADYOUT,
    output logic               HRESP,
    output logic [31:0]        HRDATA
);

    logic stall_q;
    logic err_first;   // error response, not ready yet
    logic err_second;  // error response, completing
    logic err_active;

    always_ff @(posedge HCLK) begin
        if (!HRESETn) begin
            stall_q    <= 1'b0;
            err_first  <= 1'b0;
            err_second <= 1'b0;
        end else begin
            stall_q    <= rsp.raw_stall;
            err_first  <= rsp.size_error;
            err_second <= err_first;
        end
    end

    assign err_active = err_first || err_second;

    // a stall adds one wait state, the re-read lands at the end of it
    assign HREADYOUT = !(stall_q || err_first);

    assign HRESP = err_active ? ahb_ram_pkg::hresp_error : ahb_ram_pkg::hresp_okay;

    // no data is presented while an error is being answered
    assign HRDATA = err_active ? 32'h0000_0000 : rdata.word;

endmodule

// ==== ahb_ram.sv ====
module ahb_ram #(
    parameter int addr_width = 10
) (
    input  logic                  HCLK,
    input  logic                  HRESETn,
    input  logic                  HSEL,
    input  logic [addr_width+1:0] HADDR,
    input  logic [1:0]            HTRANS,
    input  logic [2:0]            HSIZE,
    input  logic                  HWRITE,
    input  logic [31:0]           HWDATA,
    input  logic                  HREADY,
    output logic                  HREADYOUT,
    output logic                  HRESP,
    output logic [31:0]           HRDATA
);

    ahb_ram_pkg::word_t rdata;

    ahb_ram_if #(.addr_width(addr_width)) ram_bus ();

    ahb_ram_decode #(
        .addr_width (addr_width)
    ) decode_inst (
        .HCLK      (HCLK),
        .HRESETn   (HRESETn),
        .HSEL      (HSEL),
        .HADDR     (HADDR),
        .HTRANS    (HTRANS),
        .HSIZE     (HSIZE),
        .HWRITE    (HWRITE),
        .HREADY    (HREADY),
        .bus_ready (HREADYOUT), // our own wait state holds the re-read
        .dec       (ram_bus.decode)
    );

    ahb_ram_array #(
        .addr_width (addr_width)
    ) array_inst (
        .HCLK   (HCLK),
        .mem    (ram_bus.array),
        .HWDATA (HWDATA),
        .rdata  (rdata)
    );

    ahb_ram_resp resp_inst (
        .HCLK      (HCLK),
        .HRESETn   (HRESETn),
        .rsp       (ram_bus.resp),
        .rdata     (rdata),
        .HREADYOUT (HREADYOUT),
        .HRESP     (HRESP),
        .HRDATA    (HRDATA)
    );

endmodule

// ==== tb_clock.sv ====
module tb_clock (
    output logic clk
);

    timeunit 1ns;
    timeprecision 100ps;

    initial clk = 1'b0;

    always #10 clk = ~clk; // 20 ns period

endmodule

// ==== ahb_ram_chk.sv ====
module ahb_ram_chk (
    input logic HCLK,
    input logic HRESETn,
    input logic HREADYOUT,
    input logic HRESP,
    input logic write_enable,
    input logic size_error
);

    timeunit 1ns;
    timeprecision 100ps;

    // first error cycle is always followed by the completing one
    err_first_then_ready: assert property (@(posedge HCLK) disable iff (!HRESETn)
        (HRESP && !HREADYOUT) |=> (HRESP && HREADYOUT))
        else $error("error response did not complete in its second cycle");

    err_ready_after_wait: assert property (@(posedge HCLK) disable iff (!HRESETn)
        (HRESP && HREADYOUT) |-> $past(HRESP && !HREADYOUT))
        else $error("error response completed without its wait cycle");

    single_wait_state: assert property (@(posedge HCLK) disable iff (!HRESETn)
        (!HREADYOUT && !HRESP) |=> HREADYOUT)
        else $error("more than one wait state outside an error response");

    no_write_after_error: assert property (@(posedge HCLK) disable iff (!HRESETn)
        size_error |=> !write_enable)
        else $error("oversized transfer turned into a write");

endmodule

// ==== ahb_ram_tb.sv ====
module ahb_ram_tb;

    timeunit 1ns;
    timeprecision 100ps;

    localparam int addr_width  = 10;
    localparam int cycle_limit = 2000;

    logic HCLK, HRESETn, HSEL, HWRITE;
    logic [addr_width+1:0] HADDR;
    logic [1:0]  HTRANS;
    logic [2:0]  HSIZE;
    logic [31:0] HWDATA, HRDATA;
    logic HREADYOUT, HRESP;

    logic [31:0] model [2**addr_width];
    integer seed = 32'h23e7d16e;
    int errors = 0;
    int tests_run = 0;
    int tests_bad = 0;
    int cycles = 0;

    // pending transfers, one entry per address phase
    logic q_sel [$];
    logic [1:0] q_trans [$];
    logic q_write [$];
    logic [addr_width+1:0] q_addr [$];
    logic [2:0] q_size [$];
    logic [31:0] q_data [$];

    tb_clock clock_inst (.clk(HCLK));

    ahb_ram #(.addr_width(addr_width)) ahb_ram_inst (
        .HCLK(HCLK), .HRESETn(HRESETn), .HSEL(HSEL), .HADDR(HADDR),
        .HTRANS(HTRANS), .HSIZE(HSIZE), .HWRITE(HWRITE), .HWDATA(HWDATA),
        .HREADY(HREADYOUT), // single slave, its ready is the bus ready
        .HREADYOUT(HREADYOUT), .HRESP(HRESP), .HRDATA(HRDATA)
    );

    bind ahb_ram ahb_ram_chk chk_inst (
        .HCLK(HCLK), .HRESETn(HRESETn), .HREADYOUT(HREADYOUT), .HRESP(HRESP),
        .write_enable(ram_bus.write_enable), .size_error(ram_bus.size_error)
    );

    always @(posedge HCLK) begin
        cycles++;
        if (cycles >= cycle_limit) begin
            $display("run stopped after %0d cycles without reaching the end", cycles);
            $display("tests failed");
            $finish;
        end
    end

    // a transfer of 2**size bytes covers the lanes of its naturally aligned slot
    function automatic logic [3:0] lanes_for(input logic [2:0] size, input logic [1:0] low);
        logic [3:0] lanes;
        int nbytes;
        int start;
        lanes = 4'b0000;
        if (size > 3'd2) return lanes; // oversized writes nothing
        nbytes = 1 << size;
        start = low & ~(nbytes - 1);
        for (int b = 0; b < 4; b++) lanes[b] = (b >= start) && (b < start + nbytes);
        return lanes;
    endfunction

    task automatic report_fail(input string name, input logic [31:0] exp, input logic [31:0] act);
        $display("Fail %s: expected %h, actual %h", name, exp, act);
        errors++;
    endtask

    task automatic add_op(input logic sel, input logic [1:0] trans, input logic write,
                          input logic [addr_width+1:0] addr, input logic [2:0] size,
                          input logic [31:0] data);
        q_sel.push_back(sel);
        q_trans.push_back(trans);
        q_write.push_back(write);
        q_addr.push_back(addr);
        q_size.push_back(size);
        q_data.push_back(data);
    endtask

    task automatic add_write(input logic [addr_width+1:0] addr, input logic [2:0] size,
                             input logic [31:0] data);
        add_op(1'b1, ahb_ram_pkg::htrans_nonseq, 1'b1, addr, size, data);
    endtask

    task automatic add_read(input logic [addr_width+1:0] addr);
        add_op(1'b1, ahb_ram_pkg::htrans_nonseq, 1'b0, addr, ahb_ram_pkg::hsize_word, 32'h0);
    endtask

    task automatic add_idle();
        add_op(1'b0, ahb_ram_pkg::htrans_idle, 1'b0, '0, ahb_ram_pkg::hsize_word, 32'h0);
    endtask

    task automatic drive_idle();
        HSEL   = 1'b0;
        HTRANS = ahb_ram_pkg::htrans_idle;
        HWRITE = 1'b0;
    endtask

    // last cycle of a data phase, HREADYOUT is high
    task automatic finish_op(input string name, input int k);
        logic [3:0] mask;
        int w;
        mask = lanes_for(q_size[k], q_addr[k][1:0]);
        w = q_addr[k][addr_width+1:2];
        if (q_size[k] > ahb_ram_pkg::hsize_word) begin
            if (HRESP !== ahb_ram_pkg::hresp_error) report_fail({name, " hresp"}, 1, HRESP);
            if (HRDATA !== 32'h0) report_fail({name, " error data"}, 32'h0, HRDATA);
        end else begin
            if (HRESP !== ahb_ram_pkg::hresp_okay) report_fail({name, " hresp"}, 0, HRESP);
            if (q_write[k]) begin
                for (int b = 0; b < 4; b++) begin
                    if (mask[b]) model[w][8*b +: 8] = q_data[k][8*b +: 8];
                end
            end else if (HRDATA !== model[w]) begin
                report_fail({name, " read data"}, model[w], HRDATA);
            end
        end
    endtask

    task automatic run_ops(input string name, input int exp_waits);
        int idx;
        int a_op;
        int d_op;
        int waits;
        int n;
        int errs_before;
        logic ready;
        idx = 0;
        a_op = -1;
        d_op = -1;
        waits = 0;
        n = q_addr.size();
        errs_before = errors;
        while (idx < n || d_op >= 0) begin
            @(negedge HCLK);
            ready = HREADYOUT;
            // data of a non-transfer still reaches the bus, the slave must ignore it
            if (a_op >= 0) HWDATA = q_data[a_op];
            if (!ready) begin
                waits++;
                if (d_op < 0) begin
                    $display("%s: wait state with no transfer in its data phase", name);
                    errors++;
                end else if (q_size[d_op] > ahb_ram_pkg::hsize_word) begin
                    if (HRESP !== ahb_ram_pkg::hresp_error) report_fail({name, " hresp"}, 1, HRESP);
                    if (HRDATA !== 32'h0) report_fail({name, " error data"}, 32'h0, HRDATA);
                end else if (HRESP !== ahb_ram_pkg::hresp_okay) begin
                    report_fail({name, " hresp"}, 0, HRESP);
                end
                drive_idle();
            end else begin
                if (d_op >= 0) finish_op(name, d_op);
                d_op = -1;
                a_op = -1;
                if (idx < n) begin
                    HSEL   = q_sel[idx];
                    HTRANS = q_trans[idx];
                    HWRITE = q_write[idx];
                    HADDR  = q_addr[idx];
                    HSIZE  = q_size[idx];
                    a_op   = idx;
                    if (q_sel[idx] && q_trans[idx][1]) d_op = idx; // NONSEQ or SEQ
                    idx++;
                end else begin
                    drive_idle();
                end
            end
        end
        if (waits != exp_waits) report_fail({name, " wait states"}, exp_waits, waits);
        tests_run++;
        if (errors > errs_before) begin
            tests_bad++;
            $display("%s: %0d wrong", name, errors - errs_before);
        end else begin
            $display("%s: ok", name);
        end
        q_sel.delete();
        q_trans.delete();
        q_write.delete();
        q_addr.delete();
        q_size.delete();
        q_data.delete();
    endtask

    task automatic test_reset_state();
        @(negedge HCLK);
        tests_run++;
        if (HREADYOUT !== 1'b1 || HRESP !== ahb_ram_pkg::hresp_okay) begin
            report_fail("reset state", {30'h0, 2'b10}, {30'h0, HREADYOUT, HRESP});
            tests_bad++;
        end else begin
            $display("reset state: ok");
        end
    endtask

    task automatic test_word_rw();
        logic [addr_width+1:0] addrs [8];
        for (int i = 0; i < 8; i++) begin
            addrs[i] = $random(seed) & 12'hffc;
            add_write(addrs[i], ahb_ram_pkg::hsize_word, $random(seed));
        end
        add_idle();
        for (int i = 0; i < 8; i++) add_read(addrs[i]);
        run_ops("word write read", 0);
    endtask

    task automatic test_partial();
        logic [addr_width+1:0] a;
        a = $random(seed) & 12'hffc;
        add_write(a, ahb_ram_pkg::hsize_word, $random(seed));
        add_idle();
        add_write(a + 1, ahb_ram_pkg::hsize_byte, $random(seed));
        add_write(a + 2, ahb_ram_pkg::hsize_half, $random(seed));
        add_idle();
        add_read(a);
        add_write(a + 3, ahb_ram_pkg::hsize_byte, $random(seed));
        add_write(a, ahb_ram_pkg::hsize_half, $random(seed));
        add_idle();
        add_read(a);
        run_ops("byte and half writes", 0);
    endtask

    task automatic test_raw();
        logic [addr_width+1:0] a;
        logic [addr_width+1:0] b;
        a = 12'h100;
        b = 12'h204;
        add_write(b, ahb_ram_pkg::hsize_word, $random(seed));
        add_idle();
        add_write(a, ahb_ram_pkg::hsize_word, $random(seed));
        add_read(a);
        add_write(b + 2, ahb_ram_pkg::hsize_half, $random(seed));
        add_read(b);
        run_ops("read after write", 2);
    endtask

    task automatic test_unselected();
        logic [addr_width+1:0] a;
        a = 12'h3a8;
        add_write(a, ahb_ram_pkg::hsize_word, $random(seed));
        add_idle();
        add_op(1'b0, ahb_ram_pkg::htrans_nonseq, 1'b1, a, ahb_ram_pkg::hsize_word, 32'hdead_beef);
        add_op(1'b1, ahb_ram_pkg::htrans_idle, 1'b1, a, ahb_ram_pkg::hsize_word, 32'h1234_5678);
        add_op(1'b1, ahb_ram_pkg::htrans_busy, 1'b1, a, ahb_ram_pkg::hsize_word, 32'h0bad_0bad);
        add_idle();
        add_read(a);
        run_ops("unselected and idle", 0);
    endtask

    task automatic test_oversized();
        logic [addr_width+1:0] a;
        a = 12'h0f0;
        add_write(a, ahb_ram_pkg::hsize_word, $random(seed));
        add_idle();
        add_write(a, 3'b011, 32'hffff_ffff);
        add_idle(); // master cancels after the first error cycle
        add_read(a);
        run_ops("oversized transfer", 1);
    endtask

    task automatic test_stream();
        logic [addr_width+1:0] a [4];
        logic [addr_width-1:0] base;
        base = $random(seed) & 10'h3f0;
        for (int i = 0; i < 4; i++) begin
            a[i] = {base + addr_width'(i), 2'b00};
            add_write(a[i], ahb_ram_pkg::hsize_word, $random(seed));
        end
        add_idle();
        add_write(a[0], ahb_ram_pkg::hsize_word, $random(seed));
        add_read(a[1]);
        add_write(a[2], ahb_ram_pkg::hsize_word, $random(seed));
        add_read(a[3]);
        add_write(a[1], ahb_ram_pkg::hsize_word, $random(seed));
        add_read(a[0]);
        add_write(a[3], ahb_ram_pkg::hsize_word, $random(seed));
        add_read(a[2]);
        run_ops("pipelined stream", 0);
    endtask

    initial begin
        HRESETn = 1'b0;
        HSEL    = 1'b0;
        HADDR   = '0;
        HTRANS  = ahb_ram_pkg::htrans_idle;
        HSIZE   = ahb_ram_pkg::hsize_word;
        HWRITE  = 1'b0;
        HWDATA  = 32'h0;
        repeat (8) @(negedge HCLK);
        HRESETn = 1'b1;
        test_reset_state();
        test_word_rw();
        test_partial();
        test_raw();
        test_unselected();
        test_oversized();
        test_stream();
        repeat (2) @(negedge HCLK);
        $display("%0d tests run, %0d with errors, %0d wrong checks", tests_run, tests_bad, errors);
        if (errors == 0 && tests_bad == 0) begin
            $display("all tests passed");
        end else begin
            $display("tests failed");
        end
        $finish;
    end

endmodule

// ==== ahb_ram.f ====
ahb_ram_pkg.sv
ahb_ram_if.sv
ahb_ram_decode.sv
ahb_ram_array.sv
ahb_ram_resp.sv
ahb_ram.sv
tb_clock.sv
ahb_ram_chk.sv
ahb_ram_tb.sv

// ==== Makefile ====
VERILATOR ?= verilator
TOP       ?= ahb_ram_tb
RTL_TOP   ?= ahb_ram
FLIST     ?= ahb_ram.f
BUILD     ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --timing --assert

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) --lint-only $(VFLAGS) --top-module $(RTL_TOP) -f $(FLIST)

$(BUILD)/V$(TOP): $(shell cat $(FLIST))
	$(VERILATOR) --binary $(VFLAGS) --top-module $(TOP) -f $(FLIST) -Mdir $(BUILD)

sim: $(BUILD)/V$(TOP)
	./$(BUILD)/V$(TOP) > $(LOG) 2>&1 || true
	cat $(LOG)
	@if grep -q "tests failed" $(LOG); then echo "simulation FAILED"; exit 1; fi
	@if ! grep -q "all tests passed" $(LOG); then echo "simulation incomplete"; exit 1; fi

clean:
	rm -rf $(BUILD) $(LOG)
